// File: logic/encap_pkg.sv
// field widths, protocol codes, beat positions and depths shared by every filter block via wildcard import
`default_nettype none

package encap_pkg;

	typedef logic [63:0] beat_t;     // wire byte 0 in bits 7:0
	typedef logic [7:0]  keep_t;
	typedef logic [31:0] ip_addr_t;
	typedef logic [15:0] port_t;
	typedef logic [15:0] ethtype_t;
	typedef logic [7:0]  proto_t;
	typedef logic [95:0] flow_key_t; // src ip, dst ip, dst port, src port
	typedef logic [3:0]  verdict_t;
	typedef logic [9:0]  beat_idx_t;

	localparam ethtype_t ETH_TYPE_IPV4 = 16'h0800;
	localparam proto_t   IP_PROTO_UDP  = 8'h11;
	localparam verdict_t VERDICT_DROP  = 4'b0001;

	// header positions with all fields big-endian on the wire
	localparam beat_idx_t BEAT_ETHTYPE = 10'd1; // bytes 4 and 5
	localparam beat_idx_t BEAT_PROTO   = 10'd2; // byte 7
	localparam beat_idx_t BEAT_SRC_IP  = 10'd3; // src ip in bytes 2 to 5
	localparam beat_idx_t BEAT_PORTS   = 10'd4; // dst ip low half, src port, dst port

	localparam int DECODE_DELAY  = 4;
	localparam int HOLD_DEPTH    = 64;
	localparam int BYPASS_DEPTH  = 32;
	localparam int VERDICT_DEPTH = 8;
	localparam int VERDICT_AW    = $clog2(VERDICT_DEPTH);

	typedef enum logic [1:0] {MERGE_IDLE, MERGE_BYPASS, MERGE_RELEASE} merge_state_t;
	typedef enum logic [1:0] {REL_WAIT, REL_PASS, REL_DISCARD} release_state_t;

endpackage

`default_nettype wire

// File: logic/axis_if.sv
// 64-bit frame stream between filter blocks where the source drives data and the sink drives ready
`default_nettype none
`timescale 1ns/1ns

interface axis_if
	import encap_pkg::*;
();
	logic  valid;
	logic  ready;
	beat_t data;
	keep_t keep;
	logic  last;

	modport source (output valid, output data, output keep, output last, input ready);
	modport sink (input valid, input data, input keep, input last, output ready);
endinterface

`default_nettype wire

// File: logic/header_decode.sv
// rx0 header parser that issues the flow lookup and steers each frame to the bypass or hold path
`default_nettype none
`timescale 1ns/1ns

module header_decode
	import encap_pkg::*;
(
	input  logic      clk156,
	input  logic      eth_rst,
	input  logic      rx_valid,
	input  beat_t     rx_data,
	input  keep_t     rx_keep,
	input  logic      rx_last,
	output flow_key_t in_key,
	output logic      in_valid,
	axis_if.source    bypass_in,
	axis_if.source    udp_in
);
	beat_idx_t   rx_cnt;
	ethtype_t    ftype;
	proto_t      proto;
	ip_addr_t    src_ip;
	logic [15:0] dst_ip_hi;
	logic        is_udp;

	logic  dl_valid [DECODE_DELAY];
	beat_t dl_data  [DECODE_DELAY];
	keep_t dl_keep  [DECODE_DELAY];
	logic  dl_last  [DECODE_DELAY];
	logic  out_first; // next delayed beat opens a frame
	logic  frame_udp;
	logic  cls_udp;

	assign is_udp = (ftype == ETH_TYPE_IPV4) && (proto == IP_PROTO_UDP);

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			rx_cnt    <= '0;
			ftype     <= '0;
			proto     <= '0;
			src_ip    <= '0;
			dst_ip_hi <= '0;
			in_valid  <= 1'b0;
		end else begin
			in_valid <= rx_valid && (rx_cnt == BEAT_PORTS) && is_udp;
			if (rx_valid) begin
				case (rx_cnt)
					BEAT_ETHTYPE: ftype <= {rx_data[39:32], rx_data[47:40]};
					BEAT_PROTO:   proto <= rx_data[63:56];
					BEAT_SRC_IP: begin
						src_ip    <= {rx_data[23:16], rx_data[31:24],
						              rx_data[39:32], rx_data[47:40]};
						dst_ip_hi <= {rx_data[55:48], rx_data[63:56]};
					end
					default: ;
				endcase
				if (rx_last) begin // clear wins over a capture on the same beat
					rx_cnt    <= '0;
					ftype     <= '0;
					proto     <= '0;
					src_ip    <= '0;
					dst_ip_hi <= '0;
				end else if (rx_cnt != '1) begin
					rx_cnt <= rx_cnt + 1'b1;
				end
			end
		end
	end

	// key is taken straight from the ports beat so a five beat frame keeps it
	always_ff @(posedge clk156) begin
		if (rx_valid && (rx_cnt == BEAT_PORTS))
			in_key <= {src_ip, dst_ip_hi, rx_data[7:0], rx_data[15:8],
			           rx_data[39:32], rx_data[47:40], rx_data[23:16], rx_data[31:24]};
	end

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			for (int i = 0; i < DECODE_DELAY; i++)
				dl_valid[i] <= 1'b0;
			out_first <= 1'b1;
			frame_udp <= 1'b0;
		end else begin
			dl_valid[0] <= rx_valid;
			for (int i = 1; i < DECODE_DELAY; i++)
				dl_valid[i] <= dl_valid[i-1];
			if (dl_valid[DECODE_DELAY-1]) begin
				out_first <= dl_last[DECODE_DELAY-1];
				frame_udp <= cls_udp;
			end
		end
	end

	always_ff @(posedge clk156) begin
		dl_data[0] <= rx_data;
		dl_keep[0] <= rx_keep;
		dl_last[0] <= rx_last;
		for (int i = 1; i < DECODE_DELAY; i++) begin
			dl_data[i] <= dl_data[i-1];
			dl_keep[i] <= dl_keep[i-1];
			dl_last[i] <= dl_last[i-1];
		end
	end

	// proto is settled by the time beat 0 leaves the line
	assign cls_udp = out_first ? is_udp : frame_udp;

	assign bypass_in.valid = dl_valid[DECODE_DELAY-1] && !cls_udp;
	assign bypass_in.data  = dl_data[DECODE_DELAY-1];
	assign bypass_in.keep  = dl_keep[DECODE_DELAY-1];
	assign bypass_in.last  = dl_last[DECODE_DELAY-1];

	assign udp_in.valid = dl_valid[DECODE_DELAY-1] && cls_udp;
	assign udp_in.data  = dl_data[DECODE_DELAY-1];
	assign udp_in.keep  = dl_keep[DECODE_DELAY-1];
	assign udp_in.last  = dl_last[DECODE_DELAY-1];
endmodule

`default_nettype wire

// File: logic/pkt_fifo.sv
// synchronous beat FIFO with a power of two depth, instanced for the bypass and hold paths
`default_nettype none
`timescale 1ns/1ns

module pkt_fifo
	import encap_pkg::*;
#(
	parameter int DEPTH = 16
)(
	input  logic  clk156,
	input  logic  eth_rst,
	axis_if.sink  wr,
	axis_if.source rd,
	output logic  full
);
	localparam int AW = $clog2(DEPTH);

	beat_t mem_data [DEPTH];
	keep_t mem_keep [DEPTH];
	logic  mem_last [DEPTH];

	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr; // extra msb tells full from empty
	logic        empty;
	logic        do_wr;
	logic        do_rd;

	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign empty = (wr_ptr == rd_ptr);
	assign do_wr = wr.valid && !full;
	assign do_rd = rd.valid && rd.ready;

	assign wr.ready = !full;
	assign rd.valid = !empty;
	assign rd.data  = mem_data[rd_ptr[AW-1:0]];
	assign rd.keep  = mem_keep[rd_ptr[AW-1:0]];
	assign rd.last  = mem_last[rd_ptr[AW-1:0]];

	always_ff @(posedge clk156) begin
		if (do_wr) begin
			mem_data[wr_ptr[AW-1:0]] <= wr.data;
			mem_keep[wr_ptr[AW-1:0]] <= wr.keep;
			mem_last[wr_ptr[AW-1:0]] <= wr.last;
		end
	end

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end
endmodule

`default_nettype wire

// File: logic/verdict_release.sv
// queues flow table verdicts and releases or discards each held UDP frame in request order
`default_nettype none
`timescale 1ns/1ns

module verdict_release
	import encap_pkg::*;
(
	input  logic     clk156,
	input  logic     eth_rst,
	input  logic     out_valid,
	input  verdict_t out_flag,
	axis_if.sink     held,
	axis_if.source   released
);
	verdict_t            v_mem [VERDICT_DEPTH];
	logic [VERDICT_AW:0] v_wr_ptr;
	logic [VERDICT_AW:0] v_rd_ptr;
	logic                v_empty;
	logic                v_full;
	logic                v_pop;
	verdict_t            v_head;
	release_state_t      state;

	assign v_empty = (v_wr_ptr == v_rd_ptr);
	assign v_full  = (v_wr_ptr[VERDICT_AW] != v_rd_ptr[VERDICT_AW]) &&
	                 (v_wr_ptr[VERDICT_AW-1:0] == v_rd_ptr[VERDICT_AW-1:0]);
	assign v_head  = v_mem[v_rd_ptr[VERDICT_AW-1:0]];
	assign v_pop   = (state == REL_WAIT) && !v_empty;

	always_ff @(posedge clk156) begin
		if (out_valid && !v_full)
			v_mem[v_wr_ptr[VERDICT_AW-1:0]] <= out_flag;
	end

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			v_wr_ptr <= '0;
			v_rd_ptr <= '0;
			state    <= REL_WAIT;
		end else begin
			if (out_valid && !v_full)
				v_wr_ptr <= v_wr_ptr + 1'b1;
			if (v_pop)
				v_rd_ptr <= v_rd_ptr + 1'b1;
			case (state)
				REL_WAIT:
					if (!v_empty)
						state <= (v_head == VERDICT_DROP) ? REL_DISCARD : REL_PASS;
				REL_PASS:
					if (held.valid && released.ready && held.last)
						state <= REL_WAIT;
				REL_DISCARD:
					if (held.valid && held.last) // one beat per cycle into nowhere
						state <= REL_WAIT;
				default:
					state <= REL_WAIT;
			endcase
		end
	end

	assign released.valid = (state == REL_PASS) && held.valid;
	assign released.data  = held.data;
	assign released.keep  = held.keep;
	assign released.last  = held.last;

	assign held.ready = (state == REL_DISCARD) || ((state == REL_PASS) && released.ready);
endmodule

`default_nettype wire

// File: logic/tx_merge.sv
// round-robin merge of bypass and released frames onto tx1, switching only between whole frames
`default_nettype none
`timescale 1ns/1ns

module tx_merge
	import encap_pkg::*;
(
	input  logic  clk156,
	input  logic  eth_rst,
	axis_if.sink  bypass_out,
	axis_if.sink  released,
	output logic  tx_tvalid,
	output beat_t tx_tdata,
	output keep_t tx_tkeep,
	output logic  tx_tlast,
	input  logic  tx_tready
);
	merge_state_t state;
	logic         last_rel; // release stream had the last grant
	logic         out_ready;
	logic         take_byp;
	logic         take_rel;
	logic         beat_go;
	beat_t        sel_data;
	keep_t        sel_keep;
	logic         sel_last;

	assign out_ready = !tx_tvalid || tx_tready;
	assign take_byp  = (state == MERGE_BYPASS) && out_ready;
	assign take_rel  = (state == MERGE_RELEASE) && out_ready;

	assign bypass_out.ready = take_byp;
	assign released.ready   = take_rel;

	assign beat_go  = (take_byp && bypass_out.valid) || (take_rel && released.valid);
	assign sel_data = (state == MERGE_RELEASE) ? released.data : bypass_out.data;
	assign sel_keep = (state == MERGE_RELEASE) ? released.keep : bypass_out.keep;
	assign sel_last = (state == MERGE_RELEASE) ? released.last : bypass_out.last;

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			state     <= MERGE_IDLE;
			last_rel  <= 1'b0;
			tx_tvalid <= 1'b0;
		end else begin
			if (out_ready)
				tx_tvalid <= beat_go;
			case (state)
				MERGE_IDLE:
					if (bypass_out.valid && (!released.valid || last_rel)) begin
						state    <= MERGE_BYPASS;
						last_rel <= 1'b0;
					end else if (released.valid) begin
						state    <= MERGE_RELEASE;
						last_rel <= 1'b1;
					end
				MERGE_BYPASS, MERGE_RELEASE:
					if (beat_go && sel_last) // hold the grant to end of frame
						state <= MERGE_IDLE;
				default:
					state <= MERGE_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk156) begin
		if (beat_go) begin
			tx_tdata <= sel_data;
			tx_tkeep <= sel_keep;
			tx_tlast <= sel_last;
		end
	end
endmodule

`default_nettype wire

// File: logic/eth_encap.sv
// top of the UDP lookup filter that connects rx0, the flow table and tx1 through the internal blocks
`default_nettype none
`timescale 1ns/1ns

module eth_encap
	import encap_pkg::*;
(
	input  logic      clk156,
	input  logic      eth_rst,

	input  logic      s_axis_rx0_tvalid,
	input  beat_t     s_axis_rx0_tdata,
	input  keep_t     s_axis_rx0_tkeep,
	input  logic      s_axis_rx0_tlast,

	input  logic      m_axis_tx1_tready,
	output logic      m_axis_tx1_tvalid,
	output beat_t     m_axis_tx1_tdata,
	output keep_t     m_axis_tx1_tkeep,
	output logic      m_axis_tx1_tlast,

	output flow_key_t in_key,
	output logic      in_valid,
	input  logic      out_valid,
	input  verdict_t  out_flag
);
	axis_if bypass_in ();
	axis_if udp_in ();
	axis_if bypass_out ();
	axis_if held ();
	axis_if released ();

	logic bypass_full; // seen by the bound checks only
	logic hold_full;

	header_decode u_header_decode (
		.clk156    (clk156),
		.eth_rst   (eth_rst),
		.rx_valid  (s_axis_rx0_tvalid),
		.rx_data   (s_axis_rx0_tdata),
		.rx_keep   (s_axis_rx0_tkeep),
		.rx_last   (s_axis_rx0_tlast),
		.in_key    (in_key),
		.in_valid  (in_valid),
		.bypass_in (bypass_in),
		.udp_in    (udp_in)
	);

	pkt_fifo #(.DEPTH(BYPASS_DEPTH)) u_bypass_fifo (
		.clk156  (clk156),
		.eth_rst (eth_rst),
		.wr      (bypass_in),
		.rd      (bypass_out),
		.full    (bypass_full)
	);

	pkt_fifo #(.DEPTH(HOLD_DEPTH)) u_hold_fifo (
		.clk156  (clk156),
		.eth_rst (eth_rst),
		.wr      (udp_in),
		.rd      (held),
		.full    (hold_full)
	);

	verdict_release u_verdict_release (
		.clk156    (clk156),
		.eth_rst   (eth_rst),
		.out_valid (out_valid),
		.out_flag  (out_flag),
		.held      (held),
		.released  (released)
	);

	tx_merge u_tx_merge (
		.clk156     (clk156),
		.eth_rst    (eth_rst),
		.bypass_out (bypass_out),
		.released   (released),
		.tx_tvalid  (m_axis_tx1_tvalid),
		.tx_tdata   (m_axis_tx1_tdata),
		.tx_tkeep   (m_axis_tx1_tkeep),
		.tx_tlast   (m_axis_tx1_tlast),
		.tx_tready  (m_axis_tx1_tready)
	);
endmodule

`default_nettype wire

// File: test/eth_encap_properties.sv
// protocol checks on the tx1 stream, the FIFO writes and the lookup pulse, bound into eth_encap
`default_nettype none
`timescale 1ns/1ns

module eth_encap_properties
	import encap_pkg::*;
(
	input logic  clk156,
	input logic  eth_rst,
	input logic  m_axis_tx1_tvalid,
	input logic  m_axis_tx1_tready,
	input beat_t m_axis_tx1_tdata,
	input keep_t m_axis_tx1_tkeep,
	input logic  m_axis_tx1_tlast,
	input logic  in_valid,
	input logic  bypass_full,
	input logic  hold_full,
	input logic  bypass_wr,
	input logic  hold_wr
);
	a_tx_stall_stable: assert property (@(posedge clk156) disable iff (eth_rst)
		m_axis_tx1_tvalid && !m_axis_tx1_tready |=> m_axis_tx1_tvalid &&
		$stable(m_axis_tx1_tdata) && $stable(m_axis_tx1_tkeep) && $stable(m_axis_tx1_tlast))
		else $error("tx1 beat changed while stalled");

	a_bypass_no_overflow: assert property (@(posedge clk156) disable iff (eth_rst)
		!(bypass_wr && bypass_full)) else $error("write into the full bypass FIFO");

	a_hold_no_overflow: assert property (@(posedge clk156) disable iff (eth_rst)
		!(hold_wr && hold_full)) else $error("write into the full hold FIFO");

	a_lookup_pulse: assert property (@(posedge clk156) disable iff (eth_rst)
		in_valid |=> !in_valid) else $error("in_valid held longer than one cycle");

	a_quiet_after_reset: assert property (@(posedge clk156)
		$fell(eth_rst) |-> !m_axis_tx1_tvalid && !in_valid)
		else $error("tx1 valid or in_valid high right after reset");
endmodule

bind eth_encap eth_encap_properties u_properties (
	.clk156            (clk156),
	.eth_rst           (eth_rst),
	.m_axis_tx1_tvalid (m_axis_tx1_tvalid),
	.m_axis_tx1_tready (m_axis_tx1_tready),
	.m_axis_tx1_tdata  (m_axis_tx1_tdata),
	.m_axis_tx1_tkeep  (m_axis_tx1_tkeep),
	.m_axis_tx1_tlast  (m_axis_tx1_tlast),
	.in_valid          (in_valid),
	.bypass_full       (bypass_full),
	.hold_full         (hold_full),
	.bypass_wr         (bypass_in.valid),
	.hold_wr           (udp_in.valid)
);

`default_nettype wire

// File: test/tb_eth_encap.sv
// testbench for eth_encap that sends random frames, answers lookups like a flow table and checks tx1
`default_nettype none
`timescale 1ns/1ns

module tb_eth_encap
	import encap_pkg::*;
();
	localparam int KIND_ARP = 0;
	localparam int KIND_TCP = 1;
	localparam int KIND_UDP = 2;

	logic      clk156 = 1'b0;
	logic      eth_rst;
	logic      s_axis_rx0_tvalid;
	beat_t     s_axis_rx0_tdata;
	keep_t     s_axis_rx0_tkeep;
	logic      s_axis_rx0_tlast;
	logic      m_axis_tx1_tready;
	logic      m_axis_tx1_tvalid;
	beat_t     m_axis_tx1_tdata;
	keep_t     m_axis_tx1_tkeep;
	logic      m_axis_tx1_tlast;
	flow_key_t in_key;
	logic      in_valid;
	logic      out_valid = 1'b0;
	verdict_t  out_flag = '0;

	logic [31:0] lfsr;
	int          errors = 0;
	int          checks = 0;
	int          cycle = 0;
	int          last_due = 0;
	int          due;

	// beats are {last, keep, data}
	logic [72:0] exp_byp [$];
	logic [72:0] exp_udp [$];
	logic [72:0] cur [$];
	flow_key_t   exp_key [$];
	verdict_t    tbl_verdict [$];
	int          tbl_delay [$];
	int          due_q [$];
	verdict_t    ans_q [$];

	eth_encap DUT (.*);

	always #5 clk156 = ~clk156;

	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // x^32 + x^22 + x^2 + x + 1
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic [95:0] got, input logic [95:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_fault(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic send_frame(input int kind, input int vsel, input bit toggle);
		logic [72:0] beats [$];
		beat_t       b;
		keep_t       k;
		ip_addr_t    sip;
		ip_addr_t    dip;
		port_t       sp;
		port_t       dp;
		ethtype_t    et;
		proto_t      pr;
		verdict_t    v;
		int          len;
		len = 5 + int'(next_bits(3));
		sip = next_bits(32);
		dip = next_bits(32);
		sp = port_t'(next_bits(16));
		dp = port_t'(next_bits(16));
		et = (kind == KIND_ARP) ? 16'h0806 : ETH_TYPE_IPV4;
		pr = (kind == KIND_UDP) ? IP_PROTO_UDP : 8'h06;
		for (int i = 0; i < len; i++) begin
			b = {next_bits(32), next_bits(32)};
			k = 8'hff;
			case (i)
				1: b[47:32] = {et[7:0], et[15:8]};
				2: b[63:56] = pr;
				3: begin
					b[47:16] = {sip[7:0], sip[15:8], sip[23:16], sip[31:24]};
					b[63:48] = {dip[23:16], dip[31:24]};
				end
				4: b[47:0] = {dp[7:0], dp[15:8], sp[7:0], sp[15:8], dip[7:0], dip[15:8]};
				default: ;
			endcase
			if (i == len - 1)
				k = keep_t'(8'hff >> (7 - int'(next_bits(3))));
			beats.push_back({i == len - 1, k, b});
		end
		if (kind == KIND_UDP) begin
			if (vsel == 1)
				v = 4'h6;
			else if (vsel == 2 || next_bits(2) == 0)
				v = VERDICT_DROP;
			else
				v = verdict_t'(next_bits(4));
			exp_key.push_back({sip, dip, dp, sp});
			tbl_verdict.push_back(v);
			tbl_delay.push_back(5 + int'(next_bits(4))); // 5 to 20 cycles
			if (v != VERDICT_DROP)
				foreach (beats[j])
					exp_udp.push_back(beats[j]);
		end else begin
			foreach (beats[j])
				exp_byp.push_back(beats[j]);
		end
		foreach (beats[j]) begin
			@(posedge clk156);
			#1;
			s_axis_rx0_tvalid = 1'b1;
			s_axis_rx0_tdata  = beats[j][63:0];
			s_axis_rx0_tkeep  = beats[j][71:64];
			s_axis_rx0_tlast  = beats[j][72];
			if (toggle)
				m_axis_tx1_tready = (next_bits(2) != 0);
		end
		repeat (len + 2) begin // gap keeps the input below the tx1 rate
			@(posedge clk156);
			#1;
			s_axis_rx0_tvalid = 1'b0;
			s_axis_rx0_tlast  = 1'b0;
			if (toggle)
				m_axis_tx1_tready = (next_bits(2) != 0);
		end
	endtask

	task automatic wait_drained(input int limit);
		int n;
		n = 0;
		while ((exp_byp.size() != 0 || exp_udp.size() != 0 || exp_key.size() != 0 ||
		        due_q.size() != 0) && n < limit) begin
			@(posedge clk156);
			n++;
		end
		if (exp_byp.size() != 0 || exp_udp.size() != 0 || exp_key.size() != 0 || due_q.size() != 0)
			report_fault("timed out waiting for expected frames and lookups to finish");
	endtask

	// compares a finished tx1 frame with the head of its class queue
	task automatic match_frame();
		logic        udp;
		logic [72:0] e;
		udp = (cur.size() > 2) && ({cur[1][39:32], cur[1][47:40]} == ETH_TYPE_IPV4) &&
		      (cur[2][63:56] == IP_PROTO_UDP);
		for (int i = 0; i < cur.size(); i++) begin
			if (udp ? exp_udp.size() == 0 : exp_byp.size() == 0) begin
				report_fault("a frame appeared on tx1 that was not expected");
				break;
			end
			e = udp ? exp_udp.pop_front() : exp_byp.pop_front();
			check_value("m_axis_tx1_tdata", 96'(cur[i][63:0]), 96'(e[63:0]));
			check_value("m_axis_tx1_tkeep", 96'(cur[i][71:64]), 96'(e[71:64]));
			check_value("m_axis_tx1_tlast", 96'(cur[i][72]), 96'(e[72]));
		end
		cur.delete();
	endtask

	always @(posedge clk156) begin
		if (!eth_rst && m_axis_tx1_tvalid && m_axis_tx1_tready) begin
			cur.push_back({m_axis_tx1_tlast, m_axis_tx1_tkeep, m_axis_tx1_tdata});
			if (m_axis_tx1_tlast)
				match_frame();
		end
	end

	// flow table model answering in request order
	always @(posedge clk156) begin
		if (!eth_rst) begin
			cycle++;
			if (in_valid) begin
				if (exp_key.size() == 0) begin
					report_fault("in_valid pulsed although no UDP frame was waiting for a lookup");
				end else begin
					check_value("in_key", in_key, exp_key.pop_front());
					due = cycle + tbl_delay.pop_front();
					if (due <= last_due)
						due = last_due + 1;
					last_due = due;
					due_q.push_back(due);
					ans_q.push_back(tbl_verdict.pop_front());
				end
			end
		end
		#1;
		if (due_q.size() != 0 && due_q[0] <= cycle) begin
			out_valid = 1'b1;
			out_flag  = ans_q.pop_front();
			void'(due_q.pop_front());
		end else begin
			out_valid = 1'b0;
		end
	end

	initial begin
		lfsr = 32'h6d4a_438b;
		eth_rst = 1'b1;
		s_axis_rx0_tvalid = 1'b0;
		s_axis_rx0_tdata  = '0;
		s_axis_rx0_tkeep  = '0;
		s_axis_rx0_tlast  = 1'b0;
		m_axis_tx1_tready = 1'b1;
		repeat (3) @(posedge clk156);
		#1;
		eth_rst = 1'b0;

		repeat (8) begin // quiet outputs before any traffic
			@(posedge clk156);
			check_value("in_valid", 96'(in_valid), 96'(1'b0));
			check_value("m_axis_tx1_tvalid", 96'(m_axis_tx1_tvalid), 96'(1'b0));
		end

		send_frame(KIND_ARP, 0, 1'b0);
		send_frame(KIND_TCP, 0, 1'b0);
		wait_drained(500);

		send_frame(KIND_UDP, 1, 1'b0);
		send_frame(KIND_UDP, 2, 1'b0);
		send_frame(KIND_UDP, 1, 1'b0);
		wait_drained(500);

		repeat (24) begin
			send_frame((next_bits(2) >= 2) ? KIND_UDP : int'(next_bits(1)), 0, 1'b1);
		end
		m_axis_tx1_tready = 1'b1;
		wait_drained(2000);

		repeat (30) @(posedge clk156);
		if (cur.size() != 0)
			report_fault("tx1 left a frame unfinished");

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end
endmodule

`default_nettype wire

// File: filelist.f
logic/encap_pkg.sv
logic/axis_if.sv
logic/header_decode.sv
logic/pkt_fifo.sv
logic/verdict_release.sv
logic/tx_merge.sv
logic/eth_encap.sv
test/eth_encap_properties.sv
test/tb_eth_encap.sv

// File: Makefile
# Verilator build and run of the UDP lookup filter testbench

VERILATOR  ?= verilator
TOP        ?= tb_eth_encap
RTL_TOP    ?= eth_encap
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert -Wall
PASS_MSG   := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
